// ==== src/ctrlPkg.sv ====
package ctrlPkg;

  // ====================================================================
  // Widths and field types
  // ====================================================================

  localparam int wordW = 32;                // Instruction and datapath width

  typedef logic [wordW-1:0] wordT;          // Full instruction word
  typedef logic [3:0]       condT;          // Condition field, bits 31:28
  typedef logic [3:0]       flagsT;         // {N, Z, C, V}
  typedef logic [3:0]       aluCtrlT;       // Data-processing opcode to the ALU
  typedef logic [3:0]       byteMaskT;      // One bit per byte lane, lane 0 is bits 7:0
  typedef logic [1:0]       srcSelT;        // Register and immediate source selects
  typedef logic [3:0]       regNumT;        // Register file index

  // ALU opcodes used outside plain data processing
  localparam aluCtrlT opAdd = 4'b0100;      // Address add and branch target
  localparam aluCtrlT opSub = 4'b0010;      // Address subtract, U bit clear
  localparam aluCtrlT opMov = 4'b1101;      // Pass operand B, used as a harmless default

  localparam regNumT pcReg = 4'd15;         // R15

  // Major class from bits 27:26
  typedef enum logic [1:0] {
    dataProc  = 2'b00,
    loadStore = 2'b01,
    branch    = 2'b10,
    other     = 2'b11                       // Coprocessor and SWI space, not implemented
  } instrClassT;

  // ====================================================================
  // Stage control bundles
  // ====================================================================

  // Decode to Execute
  typedef struct packed {
    logic       aluSrc;                     // Immediate as operand B
    logic       memToReg;                   // Result comes from memory
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;                      // Instruction writes the PC
    logic       byteAccess;                 // LDRB or STRB
    aluCtrlT    aluCtrl;
    logic [1:0] flagWrite;                  // [1] updates NZ, [0] updates CV
  } decodeCtrlT;

  // Execute to Memory
  typedef struct packed {
    logic     memWrite;
    logic     memToReg;
    logic     regWrite;
    logic     pcSrc;
    byteMaskT byteMask;
    logic     loadByte;
  } memCtrlT;

  // Memory to Writeback
  typedef struct packed {
    logic  memToReg;
    logic  regWrite;
    logic  pcSrc;
    logic  loadByte;                        // Writeback extracts one byte
    logic  setFlags;                        // Entry commits flagsNext
    flagsT flagsNext;
  } wbCtrlT;

endpackage

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
  import ctrlPkg::*;
(
  input  wordT       instrD,
  output decodeCtrlT ctrlD,
  output srcSelT     regSrcD,
  output srcSelT     immSrcD
);

  // ====================================================================
  // Instruction fields
  // ====================================================================

  instrClassT instrClass;
  logic       immForm;                      // Bit 25, meaning depends on class
  logic       sBit;                         // Bit 20, S for data processing, L for memory
  logic       upBit;                        // Bit 23, U
  logic       byteBit;                      // Bit 22, B
  regNumT     rd;
  aluCtrlT    dpOpcode;

  // Main decoder results
  logic       aluSrc;
  logic       memToReg;
  logic       regWrite;
  logic       memWrite;
  logic       isBranch;
  logic       byteAccess;
  logic       pcSrc;

  // ALU decoder results
  aluCtrlT    aluCtrl;
  logic [1:0] flagWrite;

  assign instrClass = instrClassT'(instrD[27:26]);
  assign immForm    = instrD[25];
  assign sBit       = instrD[20];
  assign upBit      = instrD[23];
  assign byteBit    = instrD[22];
  assign rd         = instrD[15:12];
  assign dpOpcode   = instrD[24:21];

  // ====================================================================
  // Main decoder
  // ====================================================================

  always_comb begin
    // Safe defaults, no side effects
    regSrcD    = 2'b00;
    immSrcD    = 2'b00;
    aluSrc     = 1'b0;
    memToReg   = 1'b0;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    isBranch   = 1'b0;
    byteAccess = 1'b0;
    case (instrClass)
      dataProc: begin
        aluSrc   = immForm;                 // I set means rotated 8-bit immediate
        regWrite = 1'b1;                    // Compares are cleared later in Execute
      end
      loadStore: begin
        immSrcD    = 2'b01;                 // 12-bit offset
        aluSrc     = ~immForm;              // Here I clear selects the immediate
        byteAccess = byteBit;
        if (sBit) begin
          // LDR and LDRB
          memToReg = 1'b1;
          regWrite = 1'b1;
        end else begin
          // STR reads Rd as the store data source
          memWrite = 1'b1;
          regSrcD  = 2'b10;
        end
      end
      branch: begin
        regSrcD  = 2'b01;                   // Rn is the PC
        immSrcD  = 2'b10;                   // 24-bit word offset
        aluSrc   = 1'b1;
        isBranch = 1'b1;
      end
      default: begin
        // Unimplemented space decodes as a bubble
        regSrcD = 2'b00;
      end
    endcase
  end

  // ====================================================================
  // ALU decoder
  // ====================================================================

  always_comb begin
    flagWrite = 2'b00;
    case (instrClass)
      dataProc: begin
        aluCtrl   = dpOpcode;
        flagWrite = {sBit, sBit};           // S bit updates both NZ and CV
      end
      loadStore: aluCtrl = upBit ? opAdd : opSub;   // Offset direction from U
      branch:    aluCtrl = opAdd;                   // PC plus offset
      default:   aluCtrl = opMov;
    endcase
  end

  // Writes to R15 redirect fetch like a branch
  assign pcSrc = isBranch | (regWrite & (rd == pcReg));

  // Bundle for the Execute register
  always_comb begin
    ctrlD            = '0;
    ctrlD.aluSrc     = aluSrc;
    ctrlD.memToReg   = memToReg;
    ctrlD.regWrite   = regWrite;
    ctrlD.memWrite   = memWrite;
    ctrlD.branch     = isBranch;
    ctrlD.pcSrc      = pcSrc;
    ctrlD.byteAccess = byteAccess;
    ctrlD.aluCtrl    = aluCtrl;
    ctrlD.flagWrite  = flagWrite;
  end

endmodule

// ==== src/condUnit.sv ====
`timescale 1ns/1ps

module condUnit
  import ctrlPkg::*;
(
  input  condT       condE,
  input  flagsT      flagsE,                // Forwarded flags seen by this instruction
  input  flagsT      aluFlagsE,             // Fresh flags from the ALU
  input  decodeCtrlT ctrlE,
  output logic       condExE,
  output logic       regWriteGatedE,
  output logic       memWriteGatedE,
  output logic       pcSrcGatedE,
  output logic       branchTakenE,
  output logic       setFlagsE,
  output flagsT      flagsNextE
);

  logic nFlag;
  logic zFlag;
  logic cFlag;
  logic vFlag;
  logic isCompare;                          // TST, TEQ, CMP, CMN

  assign {nFlag, zFlag, cFlag, vFlag} = flagsE;

  // ====================================================================
  // Condition check
  // ====================================================================

  always_comb begin
    case (condE)
      4'b0000: condExE = zFlag;                             // EQ
      4'b0001: condExE = ~zFlag;                            // NE
      4'b0010: condExE = cFlag;                             // CS
      4'b0011: condExE = ~cFlag;                            // CC
      4'b0100: condExE = nFlag;                             // MI
      4'b0101: condExE = ~nFlag;                            // PL
      4'b0110: condExE = vFlag;                             // VS
      4'b0111: condExE = ~vFlag;                            // VC
      4'b1000: condExE = cFlag & ~zFlag;                    // HI
      4'b1001: condExE = ~cFlag | zFlag;                    // LS
      4'b1010: condExE = (nFlag == vFlag);                  // GE
      4'b1011: condExE = (nFlag != vFlag);                  // LT
      4'b1100: condExE = ~zFlag & (nFlag == vFlag);         // GT
      4'b1101: condExE = zFlag | (nFlag != vFlag);          // LE
      4'b1110: condExE = 1'b1;                              // AL
      default: condExE = 1'b0;                              // NV, never
    endcase
  end

  // ====================================================================
  // Flag merge and side-effect gating
  // ====================================================================

  // Unselected halves keep the forwarded value
  assign flagsNextE[3:2] = ctrlE.flagWrite[1] ? aluFlagsE[3:2] : flagsE[3:2];
  assign flagsNextE[1:0] = ctrlE.flagWrite[0] ? aluFlagsE[1:0] : flagsE[1:0];

  // Opcodes 10xx only set flags, never Rd
  assign isCompare = (ctrlE.aluCtrl[3:2] == 2'b10);

  assign regWriteGatedE = ctrlE.regWrite & condExE & ~isCompare;
  assign memWriteGatedE = ctrlE.memWrite & condExE;
  assign pcSrcGatedE    = ctrlE.pcSrc & condExE & ~isCompare;   // Rd of a compare is ignored
  assign branchTakenE   = ctrlE.branch & condExE;
  assign setFlagsE      = (|ctrlE.flagWrite) & condExE;

endmodule

// ==== src/memMask.sv ====
`timescale 1ns/1ps

module memMask
  import ctrlPkg::*;
(
  input  logic       byteAccessE,           // B bit of LDR or STR
  input  logic       storeE,
  input  logic [1:0] addrLowE,              // Byte offset within the word
  output byteMaskT   byteMaskE,
  output logic       loadByteE
);

  // ====================================================================
  // Byte-lane enables, little-endian
  // ====================================================================

  always_comb begin
    if (byteAccessE) begin
      case (addrLowE)
        2'b00:   byteMaskE = 4'b0001;       // Bits 7:0
        2'b01:   byteMaskE = 4'b0010;       // Bits 15:8
        2'b10:   byteMaskE = 4'b0100;       // Bits 23:16
        default: byteMaskE = 4'b1000;       // Bits 31:24
      endcase
    end else begin
      byteMaskE = 4'b1111;                  // Word access writes every lane
    end
  end

  // Load length for the Writeback byte extractor
  assign loadByteE = byteAccessE & ~storeE;

endmodule

// ==== src/armController.sv ====
`timescale 1ns/1ps

module armController
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  // Datapath side
  input  wordT       instrD,
  input  flagsT      aluFlagsE,
  input  logic [1:0] addrLowE,              // ALU result bits 1:0
  output srcSelT     regSrcD,
  output srcSelT     immSrcD,
  output logic       aluSrcD,
  output logic       aluSrcE,
  output aluCtrlT    aluCtrlE,
  output logic       branchTakenE,
  output logic       memWriteM,
  output byteMaskT   byteMaskM,
  output logic       memToRegM,
  output logic       memToRegW,
  output logic       regWriteW,
  output logic       pcSrcW,
  output logic       loadByteW,
  output flagsT      flagsW,                // Architectural NZCV
  // Hazard unit side
  input  logic       stallD,
  input  logic       flushE,
  input  logic       stallE,
  input  logic       flushM,
  input  logic       stallM,
  input  logic       flushW,
  input  logic       stallW,
  output logic       regWriteM,
  output logic       memToRegE,
  output logic       pcWrPendingF
);

  decodeCtrlT ctrlD;
  decodeCtrlT ctrlLiveD;                    // Decode controls with writes killed until valid
  logic       validD;
  decodeCtrlT ctrlE;
  condT       condE;
  flagsT      flagsE;
  flagsT      flagsNextE;
  logic       condExE;
  logic       regWriteGatedE;
  logic       memWriteGatedE;
  logic       pcSrcGatedE;
  logic       setFlagsE;
  byteMaskT   byteMaskE;
  logic       loadByteE;
  memCtrlT    memCtrlE;
  memCtrlT    memCtrlM;
  logic       setFlagsM;
  flagsT      flagsNextM;
  wbCtrlT     wbCtrlM;
  wbCtrlT     wbCtrlW;

  // ====================================================================
  // Decode
  // ====================================================================

  instrDecoder uDecoder (
    .instrD  (instrD),
    .ctrlD   (ctrlD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD)
  );

  assign aluSrcD = ctrlD.aluSrc;

  // First fetch after reset has not landed in D yet
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) validD <= 1'b0;
    else if (!stallD) validD <= 1'b1;
  end

  always_comb begin
    ctrlLiveD           = ctrlD;
    ctrlLiveD.memToReg  = ctrlD.memToReg & validD;
    ctrlLiveD.regWrite  = ctrlD.regWrite & validD;
    ctrlLiveD.memWrite  = ctrlD.memWrite & validD;
    ctrlLiveD.branch    = ctrlD.branch & validD;
    ctrlLiveD.pcSrc     = ctrlD.pcSrc & validD;
    ctrlLiveD.flagWrite = ctrlD.flagWrite & {2{validD}};
  end

  // ====================================================================
  // Execute
  // ====================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE <= '0;
      condE <= '0;
    end else if (flushE) begin
      ctrlE <= '0;                          // Flush wins over stall
      condE <= '0;
    end else if (!stallE) begin
      ctrlE <= ctrlLiveD;
      condE <= instrD[31:28];
    end
  end

  // Newest pending update first, then the committed flags
  assign flagsE = setFlagsM       ? flagsNextM :
                  wbCtrlW.setFlags ? wbCtrlW.flagsNext : flagsW;

  condUnit uCond (
    .condE          (condE),
    .flagsE         (flagsE),
    .aluFlagsE      (aluFlagsE),
    .ctrlE          (ctrlE),
    .condExE        (condExE),
    .regWriteGatedE (regWriteGatedE),
    .memWriteGatedE (memWriteGatedE),
    .pcSrcGatedE    (pcSrcGatedE),
    .branchTakenE   (branchTakenE),
    .setFlagsE      (setFlagsE),
    .flagsNextE     (flagsNextE)
  );

  memMask uMask (
    .byteAccessE (ctrlE.byteAccess),
    .storeE      (ctrlE.memWrite),
    .addrLowE    (addrLowE),
    .byteMaskE   (byteMaskE),
    .loadByteE   (loadByteE)
  );

  assign aluSrcE   = ctrlE.aluSrc;
  assign aluCtrlE  = ctrlE.aluCtrl;
  assign memToRegE = ctrlE.memToReg;

  assign memCtrlE = '{memWrite: memWriteGatedE, memToReg: ctrlE.memToReg,
                      regWrite: regWriteGatedE, pcSrc: pcSrcGatedE,
                      byteMask: byteMaskE, loadByte: loadByteE & condExE};

  // ====================================================================
  // Memory
  // ====================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlM   <= '0;
      setFlagsM  <= 1'b0;
      flagsNextM <= '0;
    end else if (flushM) begin
      memCtrlM   <= '0;
      setFlagsM  <= 1'b0;
      flagsNextM <= '0;
    end else if (!stallM) begin
      memCtrlM   <= memCtrlE;
      setFlagsM  <= setFlagsE;
      flagsNextM <= flagsNextE;
    end
  end

  assign memWriteM = memCtrlM.memWrite;
  assign byteMaskM = memCtrlM.byteMask;
  assign memToRegM = memCtrlM.memToReg;
  assign regWriteM = memCtrlM.regWrite;

  assign wbCtrlM = '{memToReg: memCtrlM.memToReg, regWrite: memCtrlM.regWrite,
                     pcSrc: memCtrlM.pcSrc, loadByte: memCtrlM.loadByte,
                     setFlags: setFlagsM, flagsNext: flagsNextM};

  // ====================================================================
  // Writeback
  // ====================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) wbCtrlW <= '0;
    else if (flushW) wbCtrlW <= '0;
    else if (!stallW) wbCtrlW <= wbCtrlM;
  end

  assign memToRegW = wbCtrlW.memToReg;
  assign regWriteW = wbCtrlW.regWrite;
  assign pcSrcW    = wbCtrlW.pcSrc;
  assign loadByteW = wbCtrlW.loadByte;

  // Commit at the edge that retires the W entry
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) flagsW <= '0;
    else if (wbCtrlW.setFlags && !stallW) flagsW <= wbCtrlW.flagsNext;
  end

  // Fetch waits while any PC write is still in flight
  assign pcWrPendingF = ctrlLiveD.pcSrc | ctrlE.pcSrc | memCtrlM.pcSrc;

endmodule

// ==== verif/tbVectors.svh ====
// Columns are instr, randMask, aluFlags, addrLow and hazards, then the expected
// expD, expAluCtrlE, expE, expM, expW and expFlagsW seen while the row is applied
// Rows 0-3 basic decode, 4-6 failing conditions, 7-11 flag chaining
vectors[0]  = '{32'hE2801000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00001, 4'hD, 4'b0000, 7'b0111100, 4'b0000, 4'h0};   // ADD imm
vectors[1]  = '{32'hE5801000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b10011, 4'h4, 4'b1000, 7'b0111100, 4'b0000, 4'h0};   // STR
vectors[2]  = '{32'hE5901000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00011, 4'h4, 4'b1000, 7'b0111101, 4'b0000, 4'h0};   // LDR
vectors[3]  = '{32'hEA000000, 32'h00FFFFFF, 4'h0, 2'd0, 7'h00,
                5'b01101, 4'h4, 4'b1101, 7'b1111100, 4'b0100, 4'h0};   // B
vectors[4]  = '{32'h02801000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00001, 4'h4, 4'b1011, 7'b0111111, 4'b0000, 4'h0};   // ADDEQ with Z clear
vectors[5]  = '{32'h05801000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b10011, 4'h4, 4'b1001, 7'b0111100, 4'b1100, 4'h0};   // STREQ
vectors[6]  = '{32'h0A000000, 32'h00FFFFFF, 4'h0, 2'd0, 7'h00,
                5'b01101, 4'h4, 4'b1001, 7'b0111100, 4'b0010, 4'h0};   // BEQ not taken
vectors[7]  = '{32'hE0501000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00000, 4'h4, 4'b1001, 7'b0111100, 4'b0000, 4'h0};   // SUBS
vectors[8]  = '{32'h0A000000, 32'h00FFFFFF, 4'h4, 2'd0, 7'h00,
                5'b01101, 4'h2, 4'b0001, 7'b0111100, 4'b0000, 4'h0};   // BEQ after Z set
vectors[9]  = '{32'hE0501000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00000, 4'h4, 4'b1011, 7'b0111101, 4'b0000, 4'h0};   // SUBS
vectors[10] = '{32'h0A000000, 32'h00FFFFFF, 4'h2, 2'd0, 7'h00,
                5'b01101, 4'h2, 4'b0001, 7'b0111100, 4'b0100, 4'h0};   // BEQ after Z clear
vectors[11] = '{32'hE3500000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00001, 4'h4, 4'b1001, 7'b0111101, 4'b0010, 4'h4};   // CMP
// Rows 12-16 byte lanes, 17-20 stall and flush, then drain
vectors[12] = '{32'hE5C01000, 32'h000F0FFF, 4'h8, 2'd0, 7'h00,
                5'b10011, 4'hA, 4'b1000, 7'b0111100, 4'b0100, 4'h4};   // STRB
vectors[13] = '{32'hE5C01000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b10011, 4'h4, 4'b1000, 7'b0111100, 4'b0000, 4'h2};
vectors[14] = '{32'hE5C01000, 32'h000F0FFF, 4'h0, 2'd1, 7'h00,
                5'b10011, 4'h4, 4'b1000, 7'b1000100, 4'b0000, 4'h2};
vectors[15] = '{32'hE5C01000, 32'h000F0FFF, 4'h0, 2'd2, 7'h00,
                5'b10011, 4'h4, 4'b1000, 7'b1001000, 4'b0000, 4'h8};
vectors[16] = '{32'hE5D01000, 32'h000F0FFF, 4'h0, 2'd3, 7'h00,
                5'b00011, 4'h4, 4'b1000, 7'b1010000, 4'b0000, 4'h8};   // LDRB
vectors[17] = '{32'hE2401000, 32'h000F0FFF, 4'h0, 2'd2, 7'h00,
                5'b00001, 4'h4, 4'b1100, 7'b1100000, 4'b0000, 4'h8};   // SUB imm
vectors[18] = '{32'hE5901000, 32'h000F0FFF, 4'h0, 2'd0, 7'b1011000,
                5'b00011, 4'h2, 4'b1000, 7'b0010011, 4'b0000, 4'h8};   // Stall D and E while M flushes
vectors[19] = '{32'hE5901000, 32'h000F0FFF, 4'h0, 2'd0, 7'h00,
                5'b00011, 4'h2, 4'b1000, 7'b0000000, 4'b1101, 4'h8};
vectors[20] = '{32'hE5801000, 32'h000F0FFF, 4'h0, 2'd0, 7'b0100000,
                5'b10011, 4'h4, 4'b1100, 7'b0111101, 4'b0000, 4'h8};   // STR killed by flushE
vectors[21] = '{32'hEF000000, 32'h00000000, 4'h0, 2'd0, 7'h00,
                5'b00000, 4'h0, 4'b0000, 7'b0111111, 4'b0100, 4'h8};
vectors[22] = '{32'hEF000000, 32'h00000000, 4'h0, 2'd0, 7'h00,
                5'b00000, 4'hD, 4'b0000, 7'b0111100, 4'b1100, 4'h8};
vectors[23] = '{32'hEF000000, 32'h00000000, 4'h0, 2'd0, 7'h00,
                5'b00000, 4'hD, 4'b0000, 7'b0111100, 4'b0000, 4'h8};
vectors[24] = '{32'hEF000000, 32'h00000000, 4'h0, 2'd0, 7'h00,
                5'b00000, 4'hD, 4'b0000, 7'b0111100, 4'b0000, 4'h8};

// ==== verif/tbController.sv ====
`timescale 1ns/1ps

module tbController
  import ctrlPkg::*;
();

  // ====================================================================
  // Timing and table size
  // ====================================================================

  localparam int clkPeriod = 40;
  localparam int driveDelay = 2;            // Inputs change just after the rising edge
  localparam int resetCycles = 4;
  localparam int numRows = 25;
  localparam int timeoutNs = (numRows + 10) * clkPeriod;

  // One table row holds stimulus and the outputs seen during that row
  typedef struct packed {
    wordT       instr;                      // Instruction presented in Decode
    wordT       randMask;                   // Don't-care bits filled from the LFSR
    flagsT      aluFlags;                   // ALU flags of the instruction now in Execute
    logic [1:0] addrLow;                    // Address bits 1:0 of the instruction in Execute
    // {stallD, flushE, stallE, flushM, stallM, flushW, stallW}
    logic [6:0] hazards;
    logic [4:0] expD;                       // {regSrcD, immSrcD, aluSrcD}
    aluCtrlT    expAluCtrlE;
    logic [3:0] expE;                       // {aluSrcE, memToRegE, branchTakenE, pcWrPendingF}
    logic [6:0] expM;                       // {memWriteM, byteMaskM, memToRegM, regWriteM}
    logic [3:0] expW;                       // {memToRegW, regWriteW, pcSrcW, loadByteW}
    flagsT      expFlagsW;
  } vecT;

  vecT vectors [numRows];

  logic        clk;
  logic        arstN;
  wordT        instrD;
  flagsT       aluFlagsE;
  logic [1:0]  addrLowE;
  logic        stallD, flushE, stallE, flushM, stallM, flushW, stallW;
  srcSelT      regSrcD, immSrcD;
  logic        aluSrcD, aluSrcE;
  aluCtrlT     aluCtrlE;
  logic        branchTakenE;
  logic        memWriteM, memToRegM, regWriteM, memToRegE;
  byteMaskT    byteMaskM;
  logic        memToRegW, regWriteW, pcSrcW, loadByteW;
  flagsT       flagsW;
  logic        pcWrPendingF;
  logic [31:0] lfsrState;

  armController dut (
    .clk          (clk),
    .arstN        (arstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .addrLowE     (addrLowE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcD      (aluSrcD),
    .aluSrcE      (aluSrcE),
    .aluCtrlE     (aluCtrlE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .byteMaskM    (byteMaskM),
    .memToRegM    (memToRegM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .loadByteW    (loadByteW),
    .flagsW       (flagsW),
    .stallD       (stallD),
    .flushE       (flushE),
    .stallE       (stallE),
    .flushM       (flushM),
    .stallM       (stallM),
    .flushW       (flushW),
    .stallW       (stallW),
    .regWriteM    (regWriteM),
    .memToRegE    (memToRegE),
    .pcWrPendingF (pcWrPendingF)
  );

  // ====================================================================
  // Helpers
  // ====================================================================

  task automatic loadVectors();
    `include "tbVectors.svh"
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic fillDontCare(input wordT base, input wordT mask, output wordT word);
    word = base;
    for (int b = 0; b < wordW; b++) begin
      if (mask[b]) begin
        lfsrState = lfsrNext(lfsrState);    // One step per bit taken
        word[b]   = lfsrState[0];
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic applyRow(input vecT v);
    wordT word;
    fillDontCare(v.instr, v.randMask, word);
    instrD    = word;
    aluFlagsE = v.aluFlags;
    addrLowE  = v.addrLow;
    {stallD, flushE, stallE, flushM, stallM, flushW, stallW} = v.hazards;
  endtask

  task automatic checkRow(input vecT v);
    checkValue("regSrcD", 32'(v.expD[4:3]), 32'(regSrcD));
    checkValue("immSrcD", 32'(v.expD[2:1]), 32'(immSrcD));
    checkValue("aluSrcD", 32'(v.expD[0]), 32'(aluSrcD));
    checkValue("aluCtrlE", 32'(v.expAluCtrlE), 32'(aluCtrlE));
    checkValue("aluSrcE", 32'(v.expE[3]), 32'(aluSrcE));
    checkValue("memToRegE", 32'(v.expE[2]), 32'(memToRegE));
    checkValue("branchTakenE", 32'(v.expE[1]), 32'(branchTakenE));
    checkValue("pcWrPendingF", 32'(v.expE[0]), 32'(pcWrPendingF));
    checkValue("memWriteM", 32'(v.expM[6]), 32'(memWriteM));
    checkValue("byteMaskM", 32'(v.expM[5:2]), 32'(byteMaskM));
    checkValue("memToRegM", 32'(v.expM[1]), 32'(memToRegM));
    checkValue("regWriteM", 32'(v.expM[0]), 32'(regWriteM));
    checkValue("memToRegW", 32'(v.expW[3]), 32'(memToRegW));
    checkValue("regWriteW", 32'(v.expW[2]), 32'(regWriteW));
    checkValue("pcSrcW", 32'(v.expW[1]), 32'(pcSrcW));
    checkValue("loadByteW", 32'(v.expW[0]), 32'(loadByteW));
    checkValue("flagsW", 32'(v.expFlagsW), 32'(flagsW));
  endtask

  // ====================================================================
  // Clock, watchdog, main sequence
  // ====================================================================

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: the test sequence did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    lfsrState = 32'hcba4;
    arstN     = 1'b0;
    instrD    = 32'hEF000000;               // Unimplemented space decodes as a bubble
    aluFlagsE = '0;
    addrLowE  = '0;
    {stallD, flushE, stallE, flushM, stallM, flushW, stallW} = '0;
    loadVectors();
    repeat (resetCycles) @(posedge clk);
    #(driveDelay);
    // Everything quiet while in reset
    checkValue("regWriteW", 32'h0, 32'(regWriteW));
    checkValue("memWriteM", 32'h0, 32'(memWriteM));
    checkValue("pcSrcW", 32'h0, 32'(pcSrcW));
    checkValue("branchTakenE", 32'h0, 32'(branchTakenE));
    checkValue("pcWrPendingF", 32'h0, 32'(pcWrPendingF));
    checkValue("flagsW", 32'h0, 32'(flagsW));
    arstN = 1'b1;
    for (int i = 0; i < numRows; i++) begin
      @(posedge clk);
      #(driveDelay);
      applyRow(vectors[i]);
      @(negedge clk);                       // All outputs settled by mid-cycle
      checkRow(vectors[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verif
src/ctrlPkg.sv
src/instrDecoder.sv
src/condUnit.sv
src/memMask.sv
src/armController.sv
verif/tbController.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbController -f filelist.f -Mdir obj_dir
./obj_dir/VtbController | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
